// File: src.f
source/hacd_pkg.sv
source/hawk_free_list_regs.sv
source/hawk_table_mem.sv
source/hawk_pgrd_mngr.sv
source/hawk_pgrd_top.sv
testbench/hawk_pgrd_properties.sv
testbench/tb_hawk_pgrd.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the page request manager regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_hawk_pgrd -o sim_hawk_pgrd \
	&& ./obj_dir/sim_hawk_pgrd > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_hawk_pgrd.sv
`timescale 1ns/1ps
`default_nettype none
/* testbench for the page request manager top level
   directed lookup tests against a reference model of ATT and free list */

module tb_hawk_pgrd;

	// sized for about 820 load cycles plus 74 lookups of up to 20 cycles with wide margin
	localparam int CYCLE_LIMIT  = 20000;
	localparam int DONE_LIMIT   = 40;
	localparam int RAND_LOOKUPS = 64;
	localparam int KIND_HIT     = 0;
	localparam int KIND_ALLOC   = 1;
	localparam int KIND_FAIL    = 2;

	logic                  clk_i = 1'b0;
	logic                  rst_ni;
	logic                  lookup_req;
	hacd_pkg::hppa_t       hppa;
	logic                  busy;
	logic                  cfg_we;
	hacd_pkg::lst_idx_t    cfg_head;
	hacd_pkg::lst_idx_t    cfg_tail;
	logic                  load_we;
	hacd_pkg::entry_addr_t load_addr;
	hacd_pkg::entry_t      load_entry;
	logic                  lookup_done;
	logic                  lookup_hit;
	logic                  lookup_alloc;
	logic                  lookup_fail;
	hacd_pkg::ppa_t        lookup_ppa;

	// reference model of the tables
	logic           att_valid [hacd_pkg::ATT_ENTRIES];
	hacd_pkg::ppa_t att_ppa   [hacd_pkg::ATT_ENTRIES];
	hacd_pkg::ppa_t lst_ppa   [hacd_pkg::LST_ENTRY_MAX];
	int             mdl_head;
	int             mdl_tail;
	logic [31:0]    lcg_state;
	int             cycles = 0;

	hawk_pgrd_top UUT (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.lookup_req   (lookup_req),
		.hppa         (hppa),
		.busy         (busy),
		.cfg_we       (cfg_we),
		.cfg_head     (cfg_head),
		.cfg_tail     (cfg_tail),
		.load_we      (load_we),
		.load_addr    (load_addr),
		.load_entry   (load_entry),
		.lookup_done  (lookup_done),
		.lookup_hit   (lookup_hit),
		.lookup_alloc (lookup_alloc),
		.lookup_fail  (lookup_fail),
		.lookup_ppa   (lookup_ppa)
	);

	// 8 ns clock
	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// page number to host physical address
	function automatic hacd_pkg::hppa_t page_addr(input int page);
		return hacd_pkg::HPPA_BASE_ADDR + (hacd_pkg::hppa_t'(page) << hacd_pkg::PAGE_SHIFT);
	endfunction

	function automatic hacd_pkg::entry_t make_entry(input logic valid, input hacd_pkg::ppa_t ppa);
		return {valid, 15'h0, ppa};
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one entry written through the load port in two cycles
	task automatic load_entry_at(input hacd_pkg::entry_addr_t addr, input hacd_pkg::entry_t ent);
		@(posedge clk_i);
		load_we    <= 1'b1;
		load_addr  <= addr;
		load_entry <= ent;
		@(posedge clk_i);
		load_we    <= 1'b0;
	endtask

	task automatic set_att(input int page, input logic valid, input hacd_pkg::ppa_t ppa);
		att_valid[page] = valid;
		att_ppa[page]   = ppa;
		load_entry_at(hacd_pkg::entry_addr_t'(page), make_entry(valid, ppa));
	endtask

	// free list entries sit behind the 256 ATT entries
	task automatic set_lst(input int idx, input hacd_pkg::ppa_t ppa);
		lst_ppa[idx] = ppa;
		load_entry_at(hacd_pkg::entry_addr_t'(hacd_pkg::ATT_ENTRIES + idx), make_entry(1'b0, ppa));
	endtask

	task automatic configure_list(input int h, input int t);
		mdl_head = h;
		mdl_tail = t;
		@(posedge clk_i);
		cfg_we   <= 1'b1;
		cfg_head <= hacd_pkg::lst_idx_t'(h);
		cfg_tail <= hacd_pkg::lst_idx_t'(t);
		@(posedge clk_i);
		cfg_we   <= 1'b0;
	endtask

	// model lookup tries a hit before an allocation before a fail
	task automatic predict(input int page, output int kind, output hacd_pkg::ppa_t ppa);
		if (att_valid[page]) begin
			kind = KIND_HIT;
			ppa  = att_ppa[page];
		end else if (mdl_head == mdl_tail) begin
			kind = KIND_FAIL;
			ppa  = '0;
		end else begin
			kind            = KIND_ALLOC;
			ppa             = lst_ppa[mdl_head];
			att_valid[page] = 1'b1;
			att_ppa[page]   = ppa;
			mdl_head        = (mdl_head + 1) % hacd_pkg::LST_ENTRY_MAX;
		end
	endtask

	task automatic issue_req(input int page);
		@(posedge clk_i);
		lookup_req <= 1'b1;
		hppa       <= page_addr(page);
		@(posedge clk_i);
		lookup_req <= 1'b0;
	endtask

	// outputs sampled on the falling edge
	task automatic wait_done;
		int n;
		n = 0;
		@(negedge clk_i);
		while (!lookup_done) begin
			n++;
			if (n > DONE_LIMIT) begin
				$display("lookup did not finish within %0d cycles", DONE_LIMIT);
				$display("Regression failed");
				$fatal(1, "lookup hang");
			end
			@(negedge clk_i);
		end
	endtask

	task automatic check_result(input int kind, input hacd_pkg::ppa_t ppa);
		compare("busy", 64'(busy), 64'(0));
		compare("lookup_hit", 64'(lookup_hit), 64'(kind == KIND_HIT));
		compare("lookup_alloc", 64'(lookup_alloc), 64'(kind == KIND_ALLOC));
		compare("lookup_fail", 64'(lookup_fail), 64'(kind == KIND_FAIL));
		if (kind != KIND_FAIL) begin
			compare("lookup_ppa", 64'(lookup_ppa), 64'(ppa));
		end
	endtask

	task automatic check_lookup(input int page);
		int             kind;
		hacd_pkg::ppa_t ppa;
		predict(page, kind, ppa);
		issue_req(page);
		wait_done;
		check_result(kind, ppa);
	endtask

	// invalid ATT entries and free list entries with per index patterns
	task automatic preload_tables;
		for (int p = 0; p < hacd_pkg::ATT_ENTRIES; p++) begin
			set_att(p, 1'b0,
				48'h0001_0000_0000 | (hacd_pkg::ppa_t'(p) << hacd_pkg::PAGE_SHIFT));
		end
		for (int i = 0; i < hacd_pkg::LST_ENTRY_MAX; i++) begin
			set_lst(i, 48'h0004_0000_0000 | (hacd_pkg::ppa_t'(i) << hacd_pkg::PAGE_SHIFT));
		end
	endtask

	task automatic test_reset_state;
		@(negedge clk_i);
		compare("busy", 64'(busy), 64'(0));
		compare("lookup_done", 64'(lookup_done), 64'(0));
		preload_tables;
		// list still empty from reset
		check_lookup(3);
	endtask

	task automatic test_hit;
		set_att(10, 1'b1, 48'h0000_0abc_d000);
		check_lookup(10);
	endtask

	// four free pages at indices 5 to 8
	task automatic test_alloc;
		configure_list(5, 9);
		check_lookup(20);
		check_lookup(21);
		check_lookup(22);
	endtask

	task automatic test_writeback;
		check_lookup(21);
		check_lookup(20);
	endtask

	task automatic test_exhaust;
		int             kind;
		hacd_pkg::ppa_t ppa;
		check_lookup(23);
		check_lookup(24);
		predict(25, kind, ppa);
		issue_req(25);
		@(negedge clk_i);
		compare("busy", 64'(busy), 64'(1));
		// second request lands mid lookup and must be dropped
		@(posedge clk_i);
		lookup_req <= 1'b1;
		hppa       <= page_addr(10);
		@(posedge clk_i);
		lookup_req <= 1'b0;
		wait_done;
		check_result(kind, ppa);
		repeat (12) begin
			@(negedge clk_i);
			compare("lookup_done", 64'(lookup_done), 64'(0));
			compare("busy", 64'(busy), 64'(0));
		end
	endtask

	// pages 64 to 127 with every third one preloaded and 20 free entries wrapping round
	task automatic test_random_mix;
		int page;
		for (int p = 64; p < 128; p++) begin
			if (p % 3 == 0) begin
				set_att(p, 1'b1, 48'h0008_0000_0000 | (hacd_pkg::ppa_t'(p) << hacd_pkg::PAGE_SHIFT));
			end
		end
		configure_list(116, 8);
		for (int i = 0; i < RAND_LOOKUPS; i++) begin
			lcg_state = lcg_next(lcg_state);
			page      = 64 + int'(lcg_state[21:16]);
			check_lookup(page);
		end
	endtask

	initial begin
		rst_ni     = 1'b0;
		lookup_req = 1'b0;
		hppa       = '0;
		cfg_we     = 1'b0;
		cfg_head   = '0;
		cfg_tail   = '0;
		load_we    = 1'b0;
		load_addr  = '0;
		load_entry = '0;
		lcg_state  = 32'h8720;
		mdl_head   = 0;
		mdl_tail   = 0;
		repeat (2) @(posedge clk_i);
		rst_ni <= 1'b1;
		test_reset_state;
		test_hit;
		test_alloc;
		test_writeback;
		test_exhaust;
		test_random_mix;
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/hawk_pgrd_properties.sv
`timescale 1ns/1ps
`default_nettype none
/* read channel and result assertions, bound into the page request manager */

module hawk_pgrd_properties (
	input logic                clk_i,
	input logic                rst_ni,
	input hacd_pkg::mem_addr_t araddr,
	input logic                arvalid,
	input logic                arready,
	input logic                rvalid,
	input logic                rlast,
	input logic                pop,
	input logic                empty,
	input logic                lookup_done,
	input logic                lookup_hit,
	input logic                lookup_alloc,
	input logic                lookup_fail
);

	// request holds while memory stalls
	ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(arvalid && !arready) |=> (arvalid && $stable(araddr)))
		else $error("arvalid or araddr changed before arready");

	// single beat reads only
	r_last_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rvalid |-> rlast)
		else $error("rvalid without rlast");

	done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lookup_done |=> !lookup_done)
		else $error("lookup_done longer than one cycle");

	// exactly one result kind per lookup
	done_kind_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lookup_done |-> $onehot({lookup_hit, lookup_alloc, lookup_fail}))
		else $error("lookup result flags not one-hot");

	pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		pop |-> !empty)
		else $error("pop from an empty free list");

endmodule

bind hawk_pgrd_mngr hawk_pgrd_properties u_props (
	.clk_i        (clk_i),
	.rst_ni       (rst_ni),
	.araddr       (araddr),
	.arvalid      (arvalid),
	.arready      (arready),
	.rvalid       (rvalid),
	.rlast        (rlast),
	.pop          (pop),
	.empty        (empty),
	.lookup_done  (lookup_done),
	.lookup_hit   (lookup_hit),
	.lookup_alloc (lookup_alloc),
	.lookup_fail  (lookup_fail)
);

`default_nettype wire

// File: source/hawk_pgrd_top.sv
`timescale 1ns/1ps
`default_nettype none
/* top level: page request manager, free list registers and table memory */

module hawk_pgrd_top (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  lookup_req,
	input  hacd_pkg::hppa_t       hppa,
	output logic                  busy,
	input  logic                  cfg_we,
	input  hacd_pkg::lst_idx_t    cfg_head,
	input  hacd_pkg::lst_idx_t    cfg_tail,
	input  logic                  load_we,
	input  hacd_pkg::entry_addr_t load_addr,
	input  hacd_pkg::entry_t      load_entry,
	output logic                  lookup_done,
	output logic                  lookup_hit,
	output logic                  lookup_alloc,
	output logic                  lookup_fail,
	output hacd_pkg::ppa_t        lookup_ppa
);

	// read channel
	hacd_pkg::mem_addr_t   araddr;
	logic                  arvalid;
	logic                  arready;
	hacd_pkg::line_t       rdata;
	logic                  rvalid;
	logic                  rlast;
	logic                  rready;
	// free list state
	hacd_pkg::lst_idx_t    head;
	logic                  empty;
	logic                  pop;
	// ATT write-back
	logic                  upd_we;
	hacd_pkg::entry_addr_t upd_addr;
	hacd_pkg::entry_t      upd_entry;

	hawk_pgrd_mngr u_mngr (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.lookup_req   (lookup_req),
		.hppa         (hppa),
		.busy         (busy),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rlast        (rlast),
		.rready       (rready),
		.head         (head),
		.empty        (empty),
		.pop          (pop),
		.upd_we       (upd_we),
		.upd_addr     (upd_addr),
		.upd_entry    (upd_entry),
		.lookup_done  (lookup_done),
		.lookup_hit   (lookup_hit),
		.lookup_alloc (lookup_alloc),
		.lookup_fail  (lookup_fail),
		.lookup_ppa   (lookup_ppa)
	);

	hawk_free_list_regs u_free_lst (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.cfg_we   (cfg_we),
		.cfg_head (cfg_head),
		.cfg_tail (cfg_tail),
		.pop      (pop),
		.head     (head),
		.empty    (empty)
	);

	hawk_table_mem u_tbl_mem (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rlast      (rlast),
		.rready     (rready),
		.upd_we     (upd_we),
		.upd_addr   (upd_addr),
		.upd_entry  (upd_entry),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_entry (load_entry)
	);

endmodule

`default_nettype wire

// File: source/hawk_pgrd_mngr.sv
`timescale 1ns/1ps
`default_nettype none
/* page request manager: lookup FSM, read address generation,
   entry decode, free list allocation and ATT write-back */

module hawk_pgrd_mngr (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  lookup_req,
	input  hacd_pkg::hppa_t       hppa,
	output logic                  busy,
	output hacd_pkg::mem_addr_t   araddr,
	output logic                  arvalid,
	input  logic                  arready,
	input  hacd_pkg::line_t       rdata,
	input  logic                  rvalid,
	input  logic                  rlast,
	output logic                  rready,
	input  hacd_pkg::lst_idx_t    head,
	input  logic                  empty,
	output logic                  pop,
	output logic                  upd_we,
	output hacd_pkg::entry_addr_t upd_addr,
	output hacd_pkg::entry_t      upd_entry,
	output logic                  lookup_done,
	output logic                  lookup_hit,
	output logic                  lookup_alloc,
	output logic                  lookup_fail,
	output hacd_pkg::ppa_t        lookup_ppa
);

	typedef enum logic [2:0] {
		IDLE,
		ATT_REQ,
		ATT_WAIT,
		DECODE,
		LST_REQ,
		LST_WAIT,
		ALLOCATE
	} state_e;

	state_e                state_q;
	state_e                state_d;
	hacd_pkg::hppa_t       hppa_q;
	hacd_pkg::hppa_t       page_num;
	hacd_pkg::entry_addr_t att_idx;
	hacd_pkg::mem_addr_t   att_addr;
	hacd_pkg::mem_addr_t   lst_addr;
	hacd_pkg::slot_t       rd_slot;
	hacd_pkg::entry_t      ent_q;
	hacd_pkg::entry_t      ent_new;
	logic                  rready_q;
	logic                  beat;
	logic                  fin;
	logic                  fin_hit;
	logic                  fin_alloc;
	logic                  fin_fail;
	hacd_pkg::ppa_t        fin_ppa;

	// page number relative to the hppa base
	assign page_num = (hppa_q - hacd_pkg::HPPA_BASE_ADDR) >> hacd_pkg::PAGE_SHIFT;
	// ATT entry index equals the page number, bit 8 stays clear
	assign att_idx  = hacd_pkg::entry_addr_t'(page_num[hacd_pkg::ATT_IDX_W-1:0]);

	// line addresses: entry index divided by 8, times 64 bytes
	assign att_addr = hacd_pkg::HAWK_ATT_START +
		(hacd_pkg::mem_addr_t'(att_idx[hacd_pkg::ENTRY_ADDR_W-1:hacd_pkg::SLOT_W])
			<< hacd_pkg::LINE_SHIFT);
	assign lst_addr = hacd_pkg::HAWK_LIST_START +
		(hacd_pkg::mem_addr_t'(head[hacd_pkg::LST_IDX_W-1:hacd_pkg::SLOT_W])
			<< hacd_pkg::LINE_SHIFT);

	// slot of interest inside the returned line
	assign rd_slot = (state_q == LST_WAIT) ? head[hacd_pkg::SLOT_W-1:0]
		: att_idx[hacd_pkg::SLOT_W-1:0];

	// single beat, so rlast marks the only data transfer
	assign beat = rvalid && rready_q && rlast;

	// fresh ATT entry built from the popped free list ppa
	always_comb begin
		ent_new                            = '0;
		ent_new[hacd_pkg::ENTRY_VALID_BIT] = 1'b1;
		ent_new[hacd_pkg::PPA_W-1:0]       = ent_q[hacd_pkg::PPA_W-1:0];
	end

	always_comb begin
		state_d   = state_q;
		fin       = 1'b0;
		fin_hit   = 1'b0;
		fin_alloc = 1'b0;
		fin_fail  = 1'b0;
		fin_ppa   = ent_q[hacd_pkg::PPA_W-1:0];
		case (state_q)
			IDLE: begin
				if (lookup_req) begin
					state_d = ATT_REQ;
				end
			end
			// arvalid holds here until memory takes the address
			ATT_REQ: begin
				if (arready) begin
					state_d = ATT_WAIT;
				end
			end
			ATT_WAIT: begin
				if (beat) begin
					state_d = DECODE;
				end
			end
			DECODE: begin
				if (ent_q[hacd_pkg::ENTRY_VALID_BIT]) begin
					fin     = 1'b1;
					fin_hit = 1'b1;
					state_d = IDLE;
				end else if (empty) begin
					// miss with nothing to allocate
					fin      = 1'b1;
					fin_fail = 1'b1;
					fin_ppa  = '0;
					state_d  = IDLE;
				end else begin
					state_d = LST_REQ;
				end
			end
			LST_REQ: begin
				if (arready) begin
					state_d = LST_WAIT;
				end
			end
			LST_WAIT: begin
				if (beat) begin
					state_d = ALLOCATE;
				end
			end
			// pop and write-back go out in this cycle
			ALLOCATE: begin
				fin       = 1'b1;
				fin_alloc = 1'b1;
				state_d   = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= IDLE;
			rready_q     <= 1'b0;
			lookup_done  <= 1'b0;
			lookup_hit   <= 1'b0;
			lookup_alloc <= 1'b0;
			lookup_fail  <= 1'b0;
		end else begin
			state_q     <= state_d;
			// always ready for data once out of reset
			rready_q    <= 1'b1;
			lookup_done <= fin;
			// result flags held until the next done
			if (fin) begin
				lookup_hit   <= fin_hit;
				lookup_alloc <= fin_alloc;
				lookup_fail  <= fin_fail;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && lookup_req) begin
			hppa_q <= hppa;
		end
		// keep only the addressed entry of the line
		if (beat) begin
			ent_q <= rdata[rd_slot*hacd_pkg::ENTRY_W +: hacd_pkg::ENTRY_W];
		end
		if (fin) begin
			lookup_ppa <= fin_ppa;
		end
	end

	// done cycle already sees IDLE, so busy drops with it
	assign busy      = (state_q != IDLE);
	assign arvalid   = (state_q == ATT_REQ) || (state_q == LST_REQ);
	assign araddr    = (state_q == LST_REQ) ? lst_addr : att_addr;
	assign rready    = rready_q;
	assign pop       = (state_q == ALLOCATE);
	assign upd_we    = (state_q == ALLOCATE);
	assign upd_addr  = att_idx;
	assign upd_entry = ent_new;

endmodule

`default_nettype wire

// File: source/hawk_table_mem.sv
`timescale 1ns/1ps
`default_nettype none
/* cacheline table memory for ATT and free list entries
   single beat read channel, entry update port and load port */

module hawk_table_mem (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  hacd_pkg::mem_addr_t   araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output hacd_pkg::line_t       rdata,
	output logic                  rvalid,
	output logic                  rlast,
	input  logic                  rready,
	input  logic                  upd_we,
	input  hacd_pkg::entry_addr_t upd_addr,
	input  hacd_pkg::entry_t      upd_entry,
	input  logic                  load_we,
	input  hacd_pkg::entry_addr_t load_addr,
	input  hacd_pkg::entry_t      load_entry
);

	// stored entry by entry, a line is eight neighbours
	hacd_pkg::entry_t mem [hacd_pkg::TBL_LINES * hacd_pkg::ENTRIES_PER_LINE];

	hacd_pkg::line_idx_t rd_line;
	logic                ar_fire;
	logic                r_fire;

	// only one read in flight, accept again once the beat is gone
	assign arready = !rvalid;
	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	// byte address to line index
	assign rd_line = araddr[hacd_pkg::LINE_SHIFT +: hacd_pkg::LINE_IDX_W];

	// every burst is a single beat
	assign rlast = rvalid;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (r_fire) begin
			rvalid <= 1'b0;
		end
	end

	// line captured at acceptance, held while the beat waits
	always_ff @(posedge clk_i) begin
		if (ar_fire) begin
			for (int i = 0; i < hacd_pkg::ENTRIES_PER_LINE; i++) begin
				rdata[i*hacd_pkg::ENTRY_W +: hacd_pkg::ENTRY_W] <=
					mem[{rd_line, hacd_pkg::slot_t'(i)}];
			end
		end
	end

	// entry writes, the manager's update wins over a preload
	always_ff @(posedge clk_i) begin
		if (upd_we) begin
			mem[upd_addr] <= upd_entry;
		end else if (load_we) begin
			mem[load_addr] <= load_entry;
		end
	end

endmodule

`default_nettype wire

// File: source/hawk_free_list_regs.sv
`timescale 1ns/1ps
`default_nettype none
/* free list head and tail registers
   config load, pop advance and empty flag */

module hawk_free_list_regs (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               cfg_we,
	input  hacd_pkg::lst_idx_t cfg_head,
	input  hacd_pkg::lst_idx_t cfg_tail,
	input  logic               pop,
	output hacd_pkg::lst_idx_t head,
	output logic               empty
);

	hacd_pkg::lst_idx_t tail;
	hacd_pkg::lst_idx_t head_nxt;

	// head wraps at the end of the list
	always_comb begin
		if (head == hacd_pkg::lst_idx_t'(hacd_pkg::LST_ENTRY_MAX - 1)) begin
			head_nxt = '0;
		end else begin
			head_nxt = head + hacd_pkg::lst_idx_t'(1);
		end
	end

	// config load takes priority over a pop in the same cycle
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head <= '0;
			tail <= '0;
		end else if (cfg_we) begin
			head <= cfg_head;
			tail <= cfg_tail;
		end else if (pop) begin
			head <= head_nxt;
		end
	end

	// nothing left to hand out once head catches tail
	assign empty = (head == tail);

endmodule

`default_nettype wire

// File: source/hacd_pkg.sv
`default_nettype none
/* address map, table geometry and shared vector types
   for the page request manager, its free list registers and table memory */

package hacd_pkg;

	// entry and cacheline geometry
	localparam int ENTRY_W          = 64;
	localparam int ENTRIES_PER_LINE = 8;
	localparam int LINE_W           = ENTRY_W * ENTRIES_PER_LINE;
	// byte offset bits inside one 64 byte line
	localparam int LINE_SHIFT       = $clog2(LINE_W / 8);
	localparam int SLOT_W           = $clog2(ENTRIES_PER_LINE);
	localparam int ADDR_W           = 48;
	localparam int PPA_W            = 48;
	// entry layout: valid on top, ppa in the low bits
	localparam int ENTRY_VALID_BIT  = 63;

	// table memory holds ATT lines 0-31 and free list lines 32-47
	localparam int TBL_LINES        = 64;
	localparam int LINE_IDX_W       = $clog2(TBL_LINES);
	localparam int ENTRY_ADDR_W     = LINE_IDX_W + SLOT_W;
	localparam int ATT_ENTRIES      = 256;
	localparam int ATT_IDX_W        = $clog2(ATT_ENTRIES);
	localparam int LST_ENTRY_MAX    = 128;
	localparam int LST_IDX_W        = $clog2(LST_ENTRY_MAX);
	// 4k pages
	localparam int PAGE_SHIFT       = 12;

	typedef logic [ADDR_W-1:0]       hppa_t;
	typedef logic [PPA_W-1:0]        ppa_t;
	typedef logic [ADDR_W-1:0]       mem_addr_t;
	typedef logic [LINE_W-1:0]       line_t;
	typedef logic [ENTRY_W-1:0]      entry_t;
	typedef logic [LST_IDX_W-1:0]    lst_idx_t;
	// line index times 8 plus slot
	typedef logic [ENTRY_ADDR_W-1:0] entry_addr_t;
	typedef logic [SLOT_W-1:0]       slot_t;
	typedef logic [LINE_IDX_W-1:0]   line_idx_t;

	// address map
	localparam hppa_t     HPPA_BASE_ADDR  = 48'h0000_1000_0000;
	localparam mem_addr_t HAWK_ATT_START  = 48'h0000_0000_0000;
	// free list starts at line 32
	localparam mem_addr_t HAWK_LIST_START = 48'h0000_0000_0800;

endpackage

`default_nettype wire
